// ==== Makefile ====
# Verilator build and run for the APB square-root unit

SIM      := verilator
TOP      := tb_sqrt_top
RTL_TOP  := sqrt_top
FILELIST := files.f
FLAGS    := --binary --timing --assert -Wno-fatal
LINTFLAGS := --lint-only -Wall --timing
RUNARGS  := +verilator+error+limit+100
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUNARGS) 2>&1 | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || (echo "simulation ended without a pass report"; exit 1)

lint:
	$(SIM) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== files.f ====
sqrt_pkg.sv
sqrt_if.sv
sqrt_pipe.sv
sqrt_result_fifo.sv
sqrt_apb_ctrl.sv
sqrt_top.sv
tb_sqrt_assert.sv
tb_sqrt_top.sv

// ==== sqrt_apb_ctrl.sv ====
/* APB slave for the square-root unit: register decode, in-flight credit
   counting, wait states for pending results and error responses. */
`timescale 1ns/1ns

module sqrt_apb_ctrl (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_psel,
    input  logic                        i_penable,
    input  logic                        i_pwrite,
    input  logic [sqrt_pkg::ADDR_W-1:0] i_paddr,
    input  logic [sqrt_pkg::RAD_W-1:0]  i_pwdata,
    output logic [sqrt_pkg::RAD_W-1:0]  o_prdata,
    output logic                        o_pready,
    output logic                        o_pslverr,
    sqrt_if.ctrl                        c
);
    import sqrt_pkg::*;

    logic              access;       // APB access phase
    logic              rad_wr;
    logic              stat_rd;
    logic              data_rd;      // ROOT or REMAINDER read
    logic              q_empty;
    logic              none_pending;
    logic              space;
    logic              stall;
    logic              err;
    logic [CNT_W-1:0]  inflight;
    logic [CNT_W:0]    occupied;     // in flight plus queued
    logic [RAD_W-1:0]  status;

    ////////////////////////////////////////
    // decode
    ////////////////////////////////////////
    assign access  = i_psel & i_penable;
    assign rad_wr  = i_pwrite & (i_paddr == REG_RADICAND);
    assign stat_rd = ~i_pwrite & (i_paddr == REG_STATUS);
    assign data_rd = ~i_pwrite & ((i_paddr == REG_ROOT) | (i_paddr == REG_REMAINDER));

    assign q_empty      = (c.count == '0);
    assign none_pending = (inflight == '0);
    assign occupied     = {1'b0, inflight} + {1'b0, c.count};
    assign space        = (occupied < (CNT_W+1)'(FIFO_DEPTH)); // keeps the queue from overflow

    ////////////////////////////////////////
    // response
    ////////////////////////////////////////
    // a data read on an empty queue waits only while a result is on its way
    assign stall = access & data_rd & q_empty & ~none_pending;

    always_comb begin
        if (rad_wr) begin
            err = ~space;
        end else if (data_rd) begin
            err = q_empty & none_pending;  // nothing would ever arrive
        end else begin
            err = ~stat_rd;                // unmapped offset
        end
    end

    assign o_pready  = access & ~stall;
    assign o_pslverr = access & ~stall & err;

    ////////////////////////////////////////
    // datapath control
    ////////////////////////////////////////
    assign c.issue    = access & rad_wr & space;
    assign c.radicand = i_pwdata;
    assign c.pop      = access & ~i_pwrite & (i_paddr == REG_REMAINDER) & ~q_empty;

    // in-flight credits
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            inflight <= '0;
        end else begin
            case ({c.issue, c.res_valid})
                2'b10:   inflight <= inflight + 1'b1;
                2'b01:   inflight <= inflight - 1'b1;
                default: inflight <= inflight;
            endcase
        end
    end

    ////////////////////////////////////////
    // read data
    ////////////////////////////////////////
    always_comb begin
        status = '0;
        status[STAT_INFL_LSB +: STAT_FLD_W] = STAT_FLD_W'(inflight);
        status[STAT_QCNT_LSB +: STAT_FLD_W] = STAT_FLD_W'(c.count);
    end

    always_comb begin
        case (i_paddr)
            REG_STATUS:    o_prdata = status;
            REG_ROOT:      o_prdata = RAD_W'(c.head_root);
            REG_REMAINDER: o_prdata = RAD_W'(c.head_rem);
            default:       o_prdata = '0;
        endcase
    end

endmodule

// ==== sqrt_if.sv ====
/* Issue and result traffic between the APB control block, the square-root
   pipeline and the result queue. */
`timescale 1ns/1ns

interface sqrt_if;
    import sqrt_pkg::*;

    logic              issue;      // one-cycle start pulse
    logic [RAD_W-1:0]  radicand;
    logic              pop;        // drop queue head
    logic              res_valid;  // pipeline output strobe
    logic [ROOT_W-1:0] res_root;
    logic [REM_W-1:0]  res_rem;
    logic [CNT_W-1:0]  count;      // queue occupancy
    logic [ROOT_W-1:0] head_root;
    logic [REM_W-1:0]  head_rem;

    modport ctrl (
        output issue, radicand, pop,
        input  res_valid, count, head_root, head_rem
    );

    modport pipe (
        input  issue, radicand,
        output res_valid, res_root, res_rem
    );

    modport fifo (
        input  res_valid, res_root, res_rem, pop,
        output count, head_root, head_rem
    );

endinterface

// ==== sqrt_pipe.sv ====
/* Pipelined integer square root, two non-restoring steps per register stage.
   Accepts one radicand per cycle and presents root and remainder LATENCY cycles later. */
`timescale 1ns/1ns

module sqrt_pipe (
    input  logic  i_clk,
    input  logic  i_rst_n,
    sqrt_if.pipe  p
);
    import sqrt_pkg::*;

    ////////////////////////////////////////
    // stage registers
    ////////////////////////////////////////
    logic [PREM_W-1:0] rem_d  [LATENCY];   // after the two steps of a stage
    logic [PREM_W-1:0] rem_q  [LATENCY];
    logic [ROOT_W-1:0] root_d [LATENCY];
    logic [ROOT_W-1:0] root_q [LATENCY];
    logic [RAD_W-1:0]  rad_in [LATENCY];   // radicand seen by each stage
    logic [RAD_W-1:0]  rad_q  [LATENCY-1]; // last stage needs no copy
    logic [LATENCY-1:0] vld_q;

    logic [PREM_W-1:0] rem_last;
    logic [PREM_W-1:0] rem_fix;

    ////////////////////////////////////////
    // step logic
    ////////////////////////////////////////
    genvar s, j;
    generate
        for (s = 0; s < LATENCY; s++) begin : g_stage
            logic [PREM_W-1:0] rem_c  [STEPS_PER_REG+1];
            logic [ROOT_W-1:0] root_c [STEPS_PER_REG+1];

            if (s == 0) begin : g_first
                assign rem_c[0]  = '0;           // start with a zero remainder
                assign root_c[0] = '0;
                assign rad_in[s] = p.radicand;
            end else begin : g_next
                assign rem_c[0]  = rem_q[s-1];
                assign root_c[0] = root_q[s-1];
                assign rad_in[s] = rad_q[s-1];
            end

            for (j = 0; j < STEPS_PER_REG; j++) begin : g_step
                localparam int K = s * STEPS_PER_REG + j; // global step index
                logic [PREM_W:0] step_out;

                assign step_out = sqrt_step(rem_c[j], root_c[j],
                                            rad_in[s][RAD_W-1-2*K -: 2]);
                assign rem_c[j+1]  = step_out[PREM_W:1];
                assign root_c[j+1] = {root_c[j][ROOT_W-2:0], step_out[0]};
            end

            assign rem_d[s]  = rem_c[STEPS_PER_REG];
            assign root_d[s] = root_c[STEPS_PER_REG];
        end
    endgenerate

    // valid chain
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[LATENCY-2:0], p.issue};
        end
    end

    // payload, no reset
    always_ff @(posedge i_clk) begin
        for (int k = 0; k < LATENCY; k++) begin
            rem_q[k]  <= rem_d[k];
            root_q[k] <= root_d[k];
        end
        for (int k = 0; k < LATENCY - 1; k++) begin
            rad_q[k] <= rad_in[k];
        end
    end

    ////////////////////////////////////////
    // output and remainder correction
    ////////////////////////////////////////
    assign rem_last = rem_q[LATENCY-1];
    assign rem_fix  = rem_last + {1'b0, root_q[LATENCY-1], 1'b1}; // add back 2q+1

    assign p.res_valid = vld_q[LATENCY-1];
    assign p.res_root  = root_q[LATENCY-1];
    assign p.res_rem   = rem_last[PREM_W-1] ? rem_fix[REM_W-1:0]  // negative, restore
                                            : rem_last[REM_W-1:0];

endmodule

// ==== sqrt_pkg.sv ====
/* Widths, APB register map, pipeline latency and the single non-restoring step.
   Imported by the square-root datapath, the queue and the APB control block. */

package sqrt_pkg;

    ////////////////////////////////////////
    // datapath widths
    ////////////////////////////////////////
    localparam int RAD_W         = 32;            // radicand, also APB data width
    localparam int ROOT_W        = RAD_W / 2;
    localparam int REM_W         = ROOT_W + 1;
    localparam int PREM_W        = REM_W + 1;     // signed partial remainder
    localparam int STEPS         = ROOT_W;        // one root bit per step
    localparam int STEPS_PER_REG = 2;
    localparam int LATENCY       = STEPS / STEPS_PER_REG;

    ////////////////////////////////////////
    // result queue
    ////////////////////////////////////////
    localparam int FIFO_DEPTH    = 4;
    localparam int PTR_W         = $clog2(FIFO_DEPTH);
    localparam int CNT_W         = $clog2(FIFO_DEPTH + 1); // holds 0..FIFO_DEPTH

    ////////////////////////////////////////
    // APB register map
    ////////////////////////////////////////
    localparam int ADDR_W = 4;

    localparam logic [ADDR_W-1:0] REG_RADICAND  = 4'h0; // write starts a computation
    localparam logic [ADDR_W-1:0] REG_STATUS    = 4'h4;
    localparam logic [ADDR_W-1:0] REG_ROOT      = 4'h8; // peek at queue head
    localparam logic [ADDR_W-1:0] REG_REMAINDER = 4'hC; // read pops queue head

    // STATUS word fields
    localparam int STAT_INFL_LSB = 0;  // in-flight count
    localparam int STAT_QCNT_LSB = 4;  // queue count
    localparam int STAT_FLD_W    = 4;

    // One step of the modified non-restoring square root. A non-negative
    // partial remainder subtracts {root, 01}, a negative one adds {root, 11}.
    // Result is {new partial remainder, new root bit}.
    function automatic logic [PREM_W:0] sqrt_step(
        input logic [PREM_W-1:0] rem,
        input logic [ROOT_W-1:0] root,
        input logic [1:0]        pair
    );
        logic [PREM_W-1:0] shifted;
        logic [PREM_W-1:0] next_rem;

        shifted = {rem[PREM_W-3:0], pair};  // bring down the next radicand pair
        if (rem[PREM_W-1]) begin
            next_rem = shifted + {root, 2'b11};
        end else begin
            next_rem = shifted - {root, 2'b01};
        end
        return {next_rem, ~next_rem[PREM_W-1]}; // root bit is the inverted sign
    endfunction

endpackage

// ==== sqrt_result_fifo.sv ====
/* Four-entry queue of root and remainder pairs filled by the pipeline.
   The head is always visible; a pop drops it. */
`timescale 1ns/1ns

module sqrt_result_fifo (
    input  logic  i_clk,
    input  logic  i_rst_n,
    sqrt_if.fifo  f
);
    import sqrt_pkg::*;

    logic [ROOT_W-1:0] root_mem [FIFO_DEPTH];
    logic [REM_W-1:0]  rem_mem  [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count_q;

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (f.res_valid) begin
            root_mem[wr_ptr] <= f.res_root;
            rem_mem[wr_ptr]  <= f.res_rem;
        end
    end

    ////////////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_q <= '0;
        end else begin
            if (f.res_valid) begin
                wr_ptr <= wr_ptr + 1'b1;   // wraps, depth is a power of two
            end
            if (f.pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({f.res_valid, f.pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // idle or push with pop
            endcase
        end
    end

    assign f.count     = count_q;
    assign f.head_root = root_mem[rd_ptr];
    assign f.head_rem  = rem_mem[rd_ptr];

endmodule

// ==== sqrt_top.sv ====
/* Top level of the APB square-root unit with plain APB ports.
   Connects the control block, the pipeline and the result queue. */
`timescale 1ns/1ns

module sqrt_top (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_psel,
    input  logic                        i_penable,
    input  logic                        i_pwrite,
    input  logic [sqrt_pkg::ADDR_W-1:0] i_paddr,
    input  logic [sqrt_pkg::RAD_W-1:0]  i_pwdata,
    output logic [sqrt_pkg::RAD_W-1:0]  o_prdata,
    output logic                        o_pready,
    output logic                        o_pslverr
);

    sqrt_if u_if ();  // issue and result traffic

    ////////////////////////////////////////
    // APB control
    ////////////////////////////////////////
    sqrt_apb_ctrl u_ctrl (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr),
        .c         (u_if.ctrl)
    );

    ////////////////////////////////////////
    // datapath
    ////////////////////////////////////////
    sqrt_pipe u_pipe (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .p       (u_if.pipe)
    );

    sqrt_result_fifo u_fifo (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .f       (u_if.fifo)
    );

endmodule

// ==== tb_sqrt_assert.sv ====
/* Concurrent APB handshake and result latency checks, bound into the square-root
   top level. Keeps a failure count that the testbench polls. */
`timescale 1ns/1ns

module tb_sqrt_assert (
    input logic                        i_clk,
    input logic                        i_rst_n,
    input logic                        i_psel,
    input logic                        i_penable,
    input logic                        i_pwrite,
    input logic [sqrt_pkg::ADDR_W-1:0] i_paddr,
    input logic                        i_pready,
    input logic                        i_pslverr,
    input logic [sqrt_pkg::CNT_W-1:0]  i_qcount
);
    import sqrt_pkg::*;

    int   fail_cnt = 0;  // polled by the testbench
    logic rad_done;      // radicand write accepted this cycle

    assign rad_done = i_psel & i_penable & i_pready & ~i_pslverr & i_pwrite
                    & (i_paddr == REG_RADICAND);

    ////////////////////////////////////////
    // APB handshake
    ////////////////////////////////////////
    a_ready_in_access : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_pready |-> (i_psel & i_penable))
    else begin
        fail_cnt++;
        $error("o_pready high outside an access phase");
    end

    a_err_with_ready : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_pslverr |-> i_pready)
    else begin
        fail_cnt++;
        $error("o_pslverr high without o_pready");
    end

    ////////////////////////////////////////
    // result latency
    ////////////////////////////////////////
    // pipeline plus one queue cycle
    a_result_queued : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        rad_done |-> ##(LATENCY + 1) (i_qcount != '0))
    else begin
        fail_cnt++;
        $error("queue still empty nine cycles after an accepted radicand write");
    end

endmodule

bind sqrt_top tb_sqrt_assert u_sqrt_assert (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_psel    (i_psel),
    .i_penable (i_penable),
    .i_pwrite  (i_pwrite),
    .i_paddr   (i_paddr),
    .i_pready  (o_pready),
    .i_pslverr (o_pslverr),
    .i_qcount  (u_if.count)
);

// ==== tb_sqrt_top.sv ====
/* Testbench for the APB square-root unit. Drives APB accesses and checks every
   result against an integer square-root model kept in the testbench. */
`timescale 1ns/1ns

module tb_sqrt_top;
    import sqrt_pkg::*;

    localparam int N_RANDOM = 200;
    localparam int N_TESTS  = N_RANDOM + 40;  // random runs plus directed accesses
    localparam int CLK_NS   = 10;

    logic              clk;
    logic              rst_n;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [RAD_W-1:0]  pwdata;
    logic [RAD_W-1:0]  prdata;
    logic              pready;
    logic              pslverr;

    integer            seed = 5212;
    logic [RAD_W-1:0]  issued [$];            // radicands in issue order

    sqrt_top sqrt_top_i (
        .i_clk     (clk),
        .i_rst_n   (rst_n),
        .i_psel    (psel),
        .i_penable (penable),
        .i_pwrite  (pwrite),
        .i_paddr   (paddr),
        .i_pwdata  (pwdata),
        .o_prdata  (prdata),
        .o_pready  (pready),
        .o_pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(N_TESTS * (LATENCY + 20) * CLK_NS);
        abort_run("watchdog expired, the run did not finish in time");
    end

    // failures seen by the bound protocol checker
    always @(negedge clk) begin
        if (sqrt_top_i.u_sqrt_assert.fail_cnt != 0) begin
            abort_run("the bound APB protocol checker reported a failure");
        end
    end

    ////////////////////////////////////////
    // reporting and reference model
    ////////////////////////////////////////
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic expect_eq(input logic [RAD_W-1:0] got, input logic [RAD_W-1:0] exp,
                             input string what);
        assert (got == exp)
        else abort_run($sformatf("Fail at %0t ns: %s is 0x%0h, expected 0x%0h",
                                 $time, what, got, exp));
    endtask

    // largest r with r*r <= x, built one bit at a time
    function automatic logic [ROOT_W-1:0] model_root(input logic [RAD_W-1:0] x);
        logic [ROOT_W-1:0] r;
        logic [ROOT_W-1:0] t;
        longint unsigned   sq;
        r = '0;
        for (int b = ROOT_W - 1; b >= 0; b--) begin
            t  = r | (ROOT_W'(1) << b);
            sq = longint'(t) * longint'(t);
            if (sq <= longint'(x)) begin
                r = t;
            end
        end
        return r;
    endfunction

    function automatic logic [REM_W-1:0] model_rem(input logic [RAD_W-1:0] x);
        logic [RAD_W-1:0] r;
        r = RAD_W'(model_root(x));
        return REM_W'(x - r * r);
    endfunction

    ////////////////////////////////////////
    // APB driver
    ////////////////////////////////////////
    task automatic apb_xfer(input logic wr, input logic [ADDR_W-1:0] addr,
                            input logic [RAD_W-1:0] wdata, output logic [RAD_W-1:0] rdata,
                            output logic err, output int waits);
        @(posedge clk);
        psel    <= 1'b1;          // setup phase
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;          // access phase
        waits = 0;
        @(negedge clk);
        while (!pready) begin
            waits++;
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [RAD_W-1:0] data,
                             output logic err);
        logic [RAD_W-1:0] unused_rd;
        int               unused_w;
        apb_xfer(1'b1, addr, data, unused_rd, err, unused_w);
    endtask

    task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [RAD_W-1:0] data,
                            output logic err, output int waits);
        apb_xfer(1'b0, addr, '0, data, err, waits);
    endtask

    ////////////////////////////////////////
    // test steps
    ////////////////////////////////////////
    task automatic read_status(output int infl, output int qcnt);
        logic [RAD_W-1:0] d;
        logic             err;
        int               w;
        apb_read(REG_STATUS, d, err, w);
        expect_eq(err, 1'b0, "status read error flag");
        infl = int'(d[STAT_INFL_LSB +: STAT_FLD_W]);
        qcnt = int'(d[STAT_QCNT_LSB +: STAT_FLD_W]);
    endtask

    task automatic wait_drained(output int qcnt);
        int infl;
        read_status(infl, qcnt);
        while (infl != 0) begin
            read_status(infl, qcnt);
        end
    endtask

    task automatic read_result(input logic [RAD_W-1:0] x, output int root_waits);
        logic [RAD_W-1:0] d;
        logic             err;
        int               w;
        apb_read(REG_ROOT, d, err, root_waits);
        expect_eq(err, 1'b0, "root read error flag");
        expect_eq(d, RAD_W'(model_root(x)), $sformatf("root of 0x%08h", x));
        apb_read(REG_REMAINDER, d, err, w);
        expect_eq(err, 1'b0, "remainder read error flag");
        expect_eq(d, RAD_W'(model_rem(x)), $sformatf("remainder of 0x%08h", x));
    endtask

    // write, then read straight away, so the root read has to wait
    task automatic run_one(input logic [RAD_W-1:0] x);
        logic err;
        int   w;
        apb_write(REG_RADICAND, x, err);
        expect_eq(err, 1'b0, "radicand write error flag");
        read_result(x, w);
        expect_eq(w > 0, 1'b1, "root read stalled until the result arrived");
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial begin
        logic [RAD_W-1:0] corners [10];
        logic [RAD_W-1:0] x;
        logic [RAD_W-1:0] d;
        logic             err;
        int               w;
        int               infl;
        int               qcnt;

        corners = '{32'h0, 32'h1, 32'h2, 32'h3, 32'hFFFF_FFFF, 32'h4, 32'h90,
                    32'h1_0000, 32'hFFFE_0001, 32'h3FFF_0001};
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        read_status(infl, qcnt);
        expect_eq(infl + qcnt, 0, "counts after reset");

        foreach (corners[i]) begin
            run_one(corners[i]);
        end
        repeat (N_RANDOM) begin
            run_one($random(seed));
        end

        // fill every credit, then one write too many
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            x = $random(seed);
            apb_write(REG_RADICAND, x, err);
            expect_eq(err, 1'b0, "queued write error flag");
            issued.push_back(x);
        end
        apb_write(REG_RADICAND, 32'h1234_5678, err);
        expect_eq(err, 1'b1, "write with no space, error flag");
        wait_drained(qcnt);
        expect_eq(qcnt, FIFO_DEPTH, "queue count after refused write");
        while (issued.size() > 0) begin
            read_result(issued.pop_front(), w);
        end
        read_status(infl, qcnt);
        expect_eq(qcnt, 0, "queue count after all pops");

        // nothing pending and unmapped accesses
        apb_read(REG_ROOT, d, err, w);
        expect_eq(err, 1'b1, "root read with nothing pending");
        apb_read(REG_REMAINDER, d, err, w);
        expect_eq(err, 1'b1, "remainder read with nothing pending");
        apb_write(REG_STATUS, 32'hFFFF_FFFF, err);
        expect_eq(err, 1'b1, "write to a read-only offset");

        // counters follow issues, then reset clears them
        apb_write(REG_RADICAND, 32'd1000, err);
        read_status(infl, qcnt);
        expect_eq(infl, 1, "in-flight count just after a write");
        expect_eq(qcnt, 0, "queue count just after a write");
        apb_write(REG_RADICAND, 32'd2000, err);
        wait_drained(qcnt);
        expect_eq(qcnt, 2, "queue count after two results");
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        read_status(infl, qcnt);
        expect_eq(infl + qcnt, 0, "counts after a second reset");
        run_one(32'h0001_E240);

        if (sqrt_top_i.u_sqrt_assert.fail_cnt == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            abort_run("the bound APB protocol checker reported a failure");
        end
    end

endmodule
